// ==== src/sdram_defs.svh ====
`ifndef SDRAM_DEFS_SVH
`define SDRAM_DEFS_SVH

// ----------------------------------------------------------------------
// client address split into row, bank and column
// ----------------------------------------------------------------------
`define SDRAM_ADDR_W      26
`define SDRAM_ROW_W       12         // bits 25..14
`define SDRAM_BANK_W      2          // bits 13..12
`define SDRAM_COL_W       12         // bits 11..0

`define SDRAM_BUS_ADDR_W  13
`define SDRAM_WE_W        4

`define SDRAM_PRCH_ADDR   13'h0400   // A10 set, all banks

// ----------------------------------------------------------------------
// command spacing in CLK cycles
// ----------------------------------------------------------------------
`define CMD_GAP           3
`define WR_PRCH_GAP       5          // write recovery
`define ARSR_GAP          12
`define ACTV_PRCH_MIN     5          // row active time

`endif

// ==== src/sdram_cmd_pkg.sv ====
`default_nettype none

`include "sdram_defs.svh"

package sdram_cmd_pkg;

  // {RAS#, CAS#, WE#} as seen on the pins
  typedef enum logic [2:0]
  {
    MRST = 3'b000,  // mode register set
    ARSR = 3'b001,  // auto refresh
    PRCH = 3'b010,  // row close
    ACTV = 3'b011,  // row open
    WRTE = 3'b100,
    READ = 3'b101,
    BTRM = 3'b110,  // burst terminate
    NOOP = 3'b111
  } sdram_op_e;

  typedef struct packed
  {
    sdram_op_e                    op;
    logic [`SDRAM_BANK_W-1:0]     bank;
    logic [`SDRAM_BUS_ADDR_W-1:0] addr;
  } sdram_cmd_t;

endpackage

`default_nettype wire

// ==== src/sdram_port_pkg.sv ====
`default_nettype none

`include "sdram_defs.svh"

package sdram_port_pkg;

  // one client request, held until granted
  typedef struct packed
  {
    logic                       req;
    logic                       we;
    logic [`SDRAM_ADDR_W-1:0]   addr;
    logic [`SDRAM_WE_W-1:0]     we_mask;
  } port_req_t;

  // same bit order as addr[25:12], so a slice casts straight in
  typedef struct packed
  {
    logic [`SDRAM_ROW_W-1:0]    row;
    logic [`SDRAM_BANK_W-1:0]   bank;
  } page_t;

endpackage

`default_nettype wire

// ==== src/port_arbiter.sv ====
`default_nettype none

`include "sdram_defs.svh"

module port_arbiter
(
  input  logic                      CLK,
  input  logic                      RST,
  input  sdram_port_pkg::port_req_t rand_req,
  input  sdram_port_pkg::port_req_t bulk_req,
  input  sdram_port_pkg::page_t     open_page,
  input  logic                      page_active,
  input  logic                      refresh_due,
  output sdram_port_pkg::port_req_t sel_req,
  output logic                      hit_rand,
  output logic                      hit_bulk,
  output sdram_port_pkg::page_t     sel_page
);

  sdram_port_pkg::page_t rand_page;
  sdram_port_pkg::page_t bulk_page;
  sdram_port_pkg::page_t sel_page_q;
  logic                  hit_allowed;

  assign rand_page = rand_req.addr[`SDRAM_ADDR_W-1:`SDRAM_COL_W];
  assign bulk_page = bulk_req.addr[`SDRAM_ADDR_W-1:`SDRAM_COL_W];

  assign hit_allowed = page_active && !refresh_due;  // refresh closes the row first

  assign hit_rand = rand_req.req && hit_allowed && (rand_page == open_page);
  assign hit_bulk = bulk_req.req && hit_allowed && (bulk_page == open_page);

  // ----------------------------------------------------------------------
  // selection, a hit beats a miss, bulk beats rand
  // ----------------------------------------------------------------------
  always_comb
  begin
    if (hit_bulk)
      sel_req = bulk_req;
    else if (hit_rand)
      sel_req = rand_req;
    else if (bulk_req.req)
      sel_req = bulk_req;
    else
      sel_req = rand_req;
  end

  // page of the selection one cycle ago, used for ACTV
  always_ff @(posedge CLK)
  begin
    if (!RST)
      sel_page_q <= '0;
    else
      sel_page_q <= sel_req.addr[`SDRAM_ADDR_W-1:`SDRAM_COL_W];
  end

  assign sel_page = sel_page_q;

endmodule

`default_nettype wire

// ==== src/bank_tracker.sv ====
`default_nettype none

`include "sdram_defs.svh"

module bank_tracker
(
  input  logic                      CLK,
  input  logic                      RST,
  input  sdram_cmd_pkg::sdram_cmd_t last_cmd,
  input  sdram_port_pkg::page_t     act_page,
  input  logic                      refresh_strobe,
  output sdram_port_pkg::page_t     open_page,
  output logic                      page_active,
  output logic                      last_write,
  output logic                      refresh_due,
  output logic                      actv_aged
);

  localparam int AGE_W = 3;

  // a decision made the cycle after ACTV lands two cycles after it
  localparam logic [AGE_W-1:0] AGE_START = AGE_W'(2);
  localparam logic [AGE_W-1:0] AGE_MIN   = AGE_W'(`ACTV_PRCH_MIN);

  logic [AGE_W-1:0] actv_age;
  logic             refresh_ack;

  // ----------------------------------------------------------------------
  // control state, follows the command one cycle late
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      page_active <= 1'b0;
      last_write  <= 1'b0;
      refresh_ack <= refresh_strobe;  // nothing pending out of reset
      refresh_due <= 1'b0;
      actv_age    <= AGE_MIN;
    end
    else
    begin
      case (last_cmd.op)
        sdram_cmd_pkg::ACTV: page_active <= 1'b1;
        sdram_cmd_pkg::PRCH: page_active <= 1'b0;
        sdram_cmd_pkg::WRTE: last_write <= 1'b1;
        sdram_cmd_pkg::READ: last_write <= 1'b0;
        sdram_cmd_pkg::ARSR: refresh_ack <= refresh_strobe;
        default: ;
      endcase

      if (last_cmd.op == sdram_cmd_pkg::ARSR)
        refresh_due <= 1'b0;
      else
        refresh_due <= refresh_strobe ^ refresh_ack;  // strobe toggled

      if (last_cmd.op == sdram_cmd_pkg::ACTV)
        actv_age <= AGE_START;
      else if (actv_age < AGE_MIN)
        actv_age <= actv_age + 1'b1;                   // saturates
    end
  end

  always_ff @(posedge CLK)
  begin
    if (last_cmd.op == sdram_cmd_pkg::ACTV)
      open_page <= act_page;
  end

  assign actv_aged = (actv_age >= AGE_MIN);

endmodule

`default_nettype wire

// ==== src/cmd_timer.sv ====
`default_nettype none

`include "sdram_defs.svh"

module cmd_timer
(
  input  logic                      CLK,
  input  logic                      RST,
  input  sdram_cmd_pkg::sdram_cmd_t last_cmd,
  input  logic                      last_write,
  input  logic                      want_prch,
  output logic                      may_issue
);

  localparam int CNT_W = 4;

  // loads are gap - 2, one cycle for the load and one for the output register
  logic [CNT_W-1:0] gap_cnt;
  logic [CNT_W-1:0] wr_cnt;
  logic             gap_done;
  logic             wr_done;

  // ----------------------------------------------------------------------
  // gap after any command
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK)
  begin
    if (!RST)
      gap_cnt <= CNT_W'(`CMD_GAP);
    else
    begin
      case (last_cmd.op)
        sdram_cmd_pkg::ARSR: gap_cnt <= CNT_W'(`ARSR_GAP - 2);
        sdram_cmd_pkg::NOOP:
        begin
          if (!gap_done)
            gap_cnt <= gap_cnt - 1'b1;
        end
        default: gap_cnt <= CNT_W'(`CMD_GAP - 2);
      endcase
    end
  end

  // write recovery, only matters for a PRCH
  always_ff @(posedge CLK)
  begin
    if (!RST)
      wr_cnt <= '0;
    else if (last_cmd.op == sdram_cmd_pkg::WRTE)
      wr_cnt <= CNT_W'(`WR_PRCH_GAP - 2);
    else if (!wr_done)
      wr_cnt <= wr_cnt - 1'b1;
  end

  assign gap_done = (gap_cnt == '0);
  assign wr_done  = (wr_cnt == '0);

  assign may_issue = gap_done && !(want_prch && last_write && !wr_done);

endmodule

`default_nettype wire

// ==== src/cmd_issuer.sv ====
`default_nettype none

`include "sdram_defs.svh"

module cmd_issuer
(
  input  logic                      CLK,
  input  logic                      RST,
  input  sdram_port_pkg::port_req_t sel_req,
  input  logic                      hit_rand,
  input  logic                      hit_bulk,
  input  sdram_port_pkg::page_t     sel_page,
  input  logic                      page_active,
  input  logic                      refresh_due,
  input  logic                      actv_aged,
  input  logic                      may_issue,
  output sdram_cmd_pkg::sdram_cmd_t cmd,
  output logic                      want_prch,
  output logic                      grant_rand,
  output logic                      grant_bulk,
  output logic [`SDRAM_WE_W-1:0]    we_mask
);

  sdram_cmd_pkg::sdram_op_e       nxt_op;
  logic [`SDRAM_BUS_ADDR_W-1:0]   nxt_addr;
  logic [`SDRAM_BANK_W-1:0]       nxt_bank;
  logic                           nxt_grant_rand;
  logic                           nxt_grant_bulk;
  logic                           can_issue;
  logic                           page_stable;
  sdram_port_pkg::page_t          req_page;

  assign can_issue   = may_issue && (cmd.op == sdram_cmd_pkg::NOOP);  // NOOP after each command
  assign req_page    = sel_req.addr[`SDRAM_ADDR_W-1:`SDRAM_COL_W];
  assign page_stable = (sel_page == req_page);  // ACTV page matches what tracker latches
  assign want_prch   = page_active && (refresh_due || (sel_req.req && !hit_rand && !hit_bulk));

  // ----------------------------------------------------------------------
  // priority: refresh, hit, miss, open
  // ----------------------------------------------------------------------
  always_comb
  begin
    nxt_op         = sdram_cmd_pkg::NOOP;
    nxt_grant_rand = 1'b0;
    nxt_grant_bulk = 1'b0;
    if (can_issue)
    begin
      if (want_prch)
      begin
        if (actv_aged)
          nxt_op = sdram_cmd_pkg::PRCH;
      end
      else if (refresh_due)
        nxt_op = sdram_cmd_pkg::ARSR;
      else if (hit_bulk || hit_rand)
      begin
        nxt_op         = sel_req.we ? sdram_cmd_pkg::WRTE : sdram_cmd_pkg::READ;
        nxt_grant_bulk = hit_bulk;
        nxt_grant_rand = !hit_bulk;
      end
      else if (sel_req.req && page_stable)
        nxt_op = sdram_cmd_pkg::ACTV;
    end
  end

  always_comb
  begin
    nxt_addr = `SDRAM_PRCH_ADDR;
    nxt_bank = cmd.bank;                          // hold last bank
    case (nxt_op)
      sdram_cmd_pkg::READ, sdram_cmd_pkg::WRTE:
      begin
        nxt_addr = {sel_req.addr[`SDRAM_COL_W-1:0], 1'b0};
        nxt_bank = req_page.bank;
      end
      sdram_cmd_pkg::ACTV:
      begin
        nxt_addr = {sel_page.row[11:10], 1'b0, sel_page.row[9:0]};  // skip A10
        nxt_bank = sel_page.bank;
      end
      default: ;
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      cmd.op     <= sdram_cmd_pkg::NOOP;
      cmd.addr   <= `SDRAM_PRCH_ADDR;
      cmd.bank   <= '0;
      grant_rand <= 1'b0;
      grant_bulk <= 1'b0;
      we_mask    <= '0;
    end
    else
    begin
      cmd.op     <= nxt_op;
      cmd.addr   <= nxt_addr;
      cmd.bank   <= nxt_bank;
      grant_rand <= nxt_grant_rand;
      grant_bulk <= nxt_grant_bulk;
      we_mask    <= (nxt_grant_rand || nxt_grant_bulk) ? sel_req.we_mask : '0;
    end
  end

endmodule

`default_nettype wire

// ==== src/sdram_sched_top.sv ====
`default_nettype none

`include "sdram_defs.svh"

module sdram_sched_top
(
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      refresh_strobe,
  input  sdram_port_pkg::port_req_t rand_req,
  input  sdram_port_pkg::port_req_t bulk_req,
  output logic                      grant_rand,
  output logic                      grant_bulk,
  output sdram_cmd_pkg::sdram_cmd_t cmd,
  output logic [`SDRAM_WE_W-1:0]    we_mask
);

  sdram_port_pkg::port_req_t sel_req;
  sdram_port_pkg::page_t     sel_page;
  sdram_port_pkg::page_t     open_page;
  logic                      hit_rand;
  logic                      hit_bulk;
  logic                      page_active;
  logic                      last_write;
  logic                      refresh_due;
  logic                      actv_aged;
  logic                      may_issue;
  logic                      want_prch;

  port_arbiter u_port_arbiter
  (
    .CLK         (CLK),
    .RST         (RST),
    .rand_req    (rand_req),
    .bulk_req    (bulk_req),
    .open_page   (open_page),
    .page_active (page_active),
    .refresh_due (refresh_due),
    .sel_req     (sel_req),
    .hit_rand    (hit_rand),
    .hit_bulk    (hit_bulk),
    .sel_page    (sel_page)
  );

  bank_tracker u_bank_tracker
  (
    .CLK            (CLK),
    .RST            (RST),
    .last_cmd       (cmd),
    .act_page       (sel_page),
    .refresh_strobe (refresh_strobe),
    .open_page      (open_page),
    .page_active    (page_active),
    .last_write     (last_write),
    .refresh_due    (refresh_due),
    .actv_aged      (actv_aged)
  );

  cmd_timer u_cmd_timer
  (
    .CLK        (CLK),
    .RST        (RST),
    .last_cmd   (cmd),
    .last_write (last_write),
    .want_prch  (want_prch),
    .may_issue  (may_issue)
  );

  cmd_issuer u_cmd_issuer
  (
    .CLK         (CLK),
    .RST         (RST),
    .sel_req     (sel_req),
    .hit_rand    (hit_rand),
    .hit_bulk    (hit_bulk),
    .sel_page    (sel_page),
    .page_active (page_active),
    .refresh_due (refresh_due),
    .actv_aged   (actv_aged),
    .may_issue   (may_issue),
    .cmd         (cmd),
    .want_prch   (want_prch),
    .grant_rand  (grant_rand),
    .grant_bulk  (grant_bulk),
    .we_mask     (we_mask)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_sdram_sched.sv ====
`default_nettype none

`include "sdram_defs.svh"

module tb_sdram_sched;

  localparam int GRANTS_WANTED = 150;
  localparam int MAX_CYCLES    = GRANTS_WANTED * 20;  // about 3000
  localparam int STROBE_PERIOD = 200;
  localparam int REFRESH_LIMIT = 100;
  localparam int SAT           = 1000;

  logic                      CLK;
  logic                      RST;
  logic                      refresh_strobe;
  sdram_port_pkg::port_req_t rand_req;
  sdram_port_pkg::port_req_t bulk_req;
  logic                      grant_rand;
  logic                      grant_bulk;
  sdram_cmd_pkg::sdram_cmd_t cmd;
  logic [`SDRAM_WE_W-1:0]    we_mask;

  integer                    seed;
  logic                      rand_seen;
  logic                      bulk_seen;
  logic                      in_reset;
  int                        stim_cycle;

  // shadow of the SDRAM state, built from the observed commands
  logic                      page_open;
  logic [`SDRAM_ROW_W-1:0]   page_row;
  logic [`SDRAM_BANK_W-1:0]  page_bank;
  logic                      cmd_seen;
  sdram_cmd_pkg::sdram_op_e  prev_op;
  int                        since_cmd;
  int                        since_wrte;
  int                        since_actv;
  int                        refresh_wait;
  logic                      strobe_ack;
  logic                      bulk_on_page;
  int                        grant_cnt;
  int                        need_gap;
  sdram_port_pkg::port_req_t gnt_req;
  logic [`SDRAM_BUS_ADDR_W-1:0] exp_col_addr;
  logic                      is_access;

  sdram_sched_top u_sdram_sched_top
  (
    .CLK            (CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .rand_req       (rand_req),
    .bulk_req       (bulk_req),
    .grant_rand     (grant_rand),
    .grant_bulk     (grant_bulk),
    .cmd            (cmd),
    .we_mask        (we_mask)
  );

  always #5 CLK = !CLK;

  task automatic stop_failed();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    $display("error %s: got %h, expected %h", name, got, exp);
    stop_failed();
  endtask

  task automatic rule_error(input string what);
    $display("%s", what);
    stop_failed();
  endtask

  function automatic int count_up(input int n);
    return (n < SAT) ? n + 1 : n;
  endfunction

  // four rows, two banks, so hits and misses both occur
  function automatic sdram_port_pkg::port_req_t new_request(input logic [31:0] r);
    sdram_port_pkg::port_req_t q;
    logic [`SDRAM_ROW_W-1:0]   row;
    case (r[1:0])
      2'd0:    row = 12'h000;
      2'd1:    row = 12'h5a3;
      2'd2:    row = 12'hc0f;
      default: row = 12'h3ff;
    endcase
    q.req     = r[2] | r[3];                 // idle a quarter of the time
    q.we      = r[4];
    q.addr    = {row, {2{r[5]}}, r[17:6]};
    q.we_mask = r[21:18];
    return q;
  endfunction

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  always @(posedge CLK)
  begin
    rand_seen = grant_rand;
    bulk_seen = grant_bulk;
    in_reset  = !RST;
    #1;
    if (in_reset)
    begin
      rand_req   = '0;
      bulk_req   = '0;
      stim_cycle = 0;
    end
    else
    begin
      stim_cycle = stim_cycle + 1;
      if (stim_cycle % STROBE_PERIOD == 0)
        refresh_strobe = !refresh_strobe;
      if (!rand_req.req || rand_seen)
        rand_req = new_request($random(seed));
      if (!bulk_req.req || bulk_seen)
        bulk_req = new_request($random(seed));
    end
  end

  // ----------------------------------------------------------------------
  // shadow model
  // ----------------------------------------------------------------------
  assign gnt_req      = grant_bulk ? bulk_req : rand_req;
  assign exp_col_addr = {gnt_req.addr[`SDRAM_COL_W-1:0], 1'b0};
  assign need_gap     = (prev_op == sdram_cmd_pkg::ARSR) ? `ARSR_GAP : `CMD_GAP;
  assign is_access    = (cmd.op == sdram_cmd_pkg::READ) || (cmd.op == sdram_cmd_pkg::WRTE);

  always @(posedge CLK)
  begin
    if (!RST)
    begin
      page_open    <= 1'b0;
      page_row     <= '0;
      page_bank    <= '0;
      cmd_seen     <= 1'b0;
      prev_op      <= sdram_cmd_pkg::NOOP;
      since_cmd    <= SAT;
      since_wrte   <= SAT;
      since_actv   <= SAT;
      refresh_wait <= 0;
      strobe_ack   <= refresh_strobe;
      bulk_on_page <= 1'b0;
      grant_cnt    <= 0;
    end
    else
    begin
      bulk_on_page <= bulk_req.req && page_open &&
                      (bulk_req.addr[`SDRAM_ADDR_W-1:`SDRAM_COL_W] == {page_row, page_bank});
      if (grant_rand || grant_bulk)
        grant_cnt <= grant_cnt + 1;
      if (cmd.op != sdram_cmd_pkg::NOOP)
      begin
        cmd_seen  <= 1'b1;
        prev_op   <= cmd.op;
        since_cmd <= 1;
      end
      else
        since_cmd <= count_up(since_cmd);
      since_wrte <= (cmd.op == sdram_cmd_pkg::WRTE) ? 1 : count_up(since_wrte);
      since_actv <= (cmd.op == sdram_cmd_pkg::ACTV) ? 1 : count_up(since_actv);
      case (cmd.op)
        sdram_cmd_pkg::ACTV:
        begin
          page_open <= 1'b1;
          page_row  <= {cmd.addr[12:11], cmd.addr[9:0]};  // A10 skipped
          page_bank <= cmd.bank;
        end
        sdram_cmd_pkg::PRCH: page_open <= 1'b0;
        sdram_cmd_pkg::ARSR: strobe_ack <= refresh_strobe;
        default: ;
      endcase
      if (cmd.op == sdram_cmd_pkg::ARSR || refresh_strobe == strobe_ack)
        refresh_wait <= 0;
      else
        refresh_wait <= count_up(refresh_wait);
    end
  end

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  a_idle_cmd: assert property (@(posedge CLK) disable iff (!RST)
    !cmd_seen && cmd.op == sdram_cmd_pkg::NOOP |->
      cmd.addr == `SDRAM_PRCH_ADDR && cmd.bank == '0)
    else value_error("cmd", $sampled(cmd), {sdram_cmd_pkg::NOOP, 2'b00, `SDRAM_PRCH_ADDR});
  a_idle_out: assert property (@(posedge CLK) disable iff (!RST)
    !cmd_seen |-> !grant_rand && !grant_bulk && we_mask == '0)
    else value_error("grant_rand/grant_bulk/we_mask",
                     $sampled({grant_rand, grant_bulk, we_mask}), 0);

  a_gap: assert property (@(posedge CLK) disable iff (!RST)
    cmd.op != sdram_cmd_pkg::NOOP |-> since_cmd >= need_gap)
    else value_error("command gap", $sampled(since_cmd), $sampled(need_gap));
  a_wr_prch: assert property (@(posedge CLK) disable iff (!RST)
    cmd.op == sdram_cmd_pkg::PRCH |-> since_wrte >= `WR_PRCH_GAP)
    else value_error("WRTE to PRCH gap", $sampled(since_wrte), `WR_PRCH_GAP);
  a_actv_prch: assert property (@(posedge CLK) disable iff (!RST)
    cmd.op == sdram_cmd_pkg::PRCH |-> since_actv >= `ACTV_PRCH_MIN)
    else value_error("ACTV to PRCH gap", $sampled(since_actv), `ACTV_PRCH_MIN);

  a_actv_closed: assert property (@(posedge CLK) disable iff (!RST)
    cmd.op == sdram_cmd_pkg::ACTV |-> !page_open)
    else rule_error("ACTV issued while a page was already open");
  a_access_open: assert property (@(posedge CLK) disable iff (!RST)
    is_access |-> page_open)
    else rule_error("READ or WRTE issued with no page open");
  a_arsr_closed: assert property (@(posedge CLK) disable iff (!RST)
    cmd.op == sdram_cmd_pkg::ARSR |-> !page_open)
    else rule_error("ARSR issued while a page was open");

  a_grant_cmd: assert property (@(posedge CLK) disable iff (!RST)
    is_access == (grant_rand || grant_bulk))
    else rule_error("grant pulse and READ/WRTE command did not coincide");
  a_one_grant: assert property (@(posedge CLK) disable iff (!RST)
    !(grant_rand && grant_bulk))
    else rule_error("both ports were granted in the same cycle");
  a_grant_req: assert property (@(posedge CLK) disable iff (!RST)
    is_access |-> gnt_req.req)
    else rule_error("grant went to a port without a pending request");
  a_grant_page: assert property (@(posedge CLK) disable iff (!RST)
    is_access |-> gnt_req.addr[`SDRAM_ADDR_W-1:`SDRAM_COL_W] == {page_row, page_bank})
    else value_error("req page", $sampled(gnt_req.addr[`SDRAM_ADDR_W-1:`SDRAM_COL_W]),
                     $sampled({page_row, page_bank}));
  a_grant_bank: assert property (@(posedge CLK) disable iff (!RST)
    is_access |-> cmd.bank == page_bank)
    else value_error("cmd.bank", $sampled(cmd.bank), $sampled(page_bank));
  a_grant_op: assert property (@(posedge CLK) disable iff (!RST)
    is_access |-> (cmd.op == sdram_cmd_pkg::WRTE) == gnt_req.we)
    else value_error("cmd.op", $sampled(cmd.op), $sampled(gnt_req.we) ?
                     sdram_cmd_pkg::WRTE : sdram_cmd_pkg::READ);
  a_grant_addr: assert property (@(posedge CLK) disable iff (!RST)
    is_access |-> cmd.addr == exp_col_addr)
    else value_error("cmd.addr", $sampled(cmd.addr), $sampled(exp_col_addr));
  a_grant_mask: assert property (@(posedge CLK) disable iff (!RST)
    is_access |-> we_mask == gnt_req.we_mask)
    else value_error("we_mask", $sampled(we_mask), $sampled(gnt_req.we_mask));

  a_refresh: assert property (@(posedge CLK) disable iff (!RST)
    refresh_wait <= REFRESH_LIMIT)
    else rule_error("no ARSR followed a refresh strobe toggle within 100 cycles");
  a_priority: assert property (@(posedge CLK) disable iff (!RST)
    grant_rand |-> !bulk_on_page)
    else rule_error("rand port granted while bulk was pending on the open page");

  // ----------------------------------------------------------------------
  // run control
  // ----------------------------------------------------------------------
  initial
  begin
    CLK            = 1'b0;
    RST            = 1'b0;
    refresh_strobe = 1'b0;
    rand_req       = '0;
    bulk_req       = '0;
    stim_cycle     = 0;
    seed           = 32'hd28d29c7;
    repeat (2) @(posedge CLK);
    #1;
    RST = 1'b1;
    wait (grant_cnt >= GRANTS_WANTED);
    repeat (4) @(posedge CLK);
    $display("Simulation finished: PASS");
    $finish;
  end

  initial
  begin
    #(MAX_CYCLES * 10 + 500);
    rule_error("watchdog expired before enough grants were seen");
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+src
src/sdram_cmd_pkg.sv
src/sdram_port_pkg.sv
src/port_arbiter.sv
src/bank_tracker.sv
src/cmd_timer.sv
src/cmd_issuer.sv
src/sdram_sched_top.sv
testbench/tb_sdram_sched.sv
